// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

  typedef logic [15:0] cmd_t; // host command word.
  typedef logic [7:0] byte_t; // payload of one serial frame.
  typedef logic [6:0] addr_t; // remote register address.

  // command word layout.
  localparam int cmd_write_bit = 15; // set for a write, clear for a read.
  localparam int cmd_addr_msb = 14;
  localparam int cmd_addr_lsb = 8;
  localparam int cmd_data_msb = 7;
  localparam int cmd_data_lsb = 0;

  localparam int frame_bits = 11; // start, eight data, parity and stop.

  typedef enum logic [2:0] {
    idle,
    send_addr,
    gap,
    send_data,
    wait_resp,
    report
  } seq_state_t;

endpackage

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int BIT_CYCLES = 434
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             tx_start,
  input  wire uart_pkg::byte_t tx_byte,
  output logic            tx_busy,
  output logic            tx
);

  localparam int cnt_w = $clog2(BIT_CYCLES + 1);
  localparam logic [cnt_w-1:0] cyc_last = cnt_w'(BIT_CYCLES - 1);
  localparam logic [3:0] bit_last = 4'(uart_pkg::frame_bits - 1);

  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;
  logic [9:0]       shift_q; // stop, parity and data bits still to go out.
  logic             bit_end;

  assign bit_end = (cyc_cnt == cyc_last);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      tx <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!tx_busy)
    begin
      cyc_cnt <= '0;
      bit_idx <= '0;
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        tx <= 1'b0; // start bit goes out on the next cycle.
      end
    end
    else if (!bit_end)
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
    else
    begin
      cyc_cnt <= '0;
      if (bit_idx == bit_last)
      begin
        tx_busy <= 1'b0; // stop bit done, the line stays high.
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx <= shift_q[0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!tx_busy && tx_start)
    begin
      shift_q <= {1'b1, ~^tx_byte, tx_byte}; // odd parity over the data byte.
    end
    else if (tx_busy && bit_end)
    begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  // the line only ever leaves the idle level inside a frame.
  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low while the transmitter is idle.");

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none

module uart_rx #(
  parameter int BIT_CYCLES = 434
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             rx,
  output logic            rx_valid,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_err,
  output logic            rx_active
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  localparam int cnt_w = $clog2(BIT_CYCLES + 1);
  localparam logic [cnt_w-1:0] cyc_last = cnt_w'(BIT_CYCLES - 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(BIT_CYCLES / 2 - 1);

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic             sample;
  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_cnt;
  logic [8:0]       shift_q; // parity sits above the data byte once full.

  assign fall = rx_prev & ~rx_sync;
  assign sample = (cyc_cnt == cyc_last);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= rx_idle;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      rx_valid <= 1'b0;
      rx_active <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state)
        rx_idle:
        begin
          cyc_cnt <= '0;
          bit_cnt <= '0;
          if (fall)
            state <= rx_start;
        end
        rx_start:
        begin
          if (cyc_cnt == half_last)
          begin
            cyc_cnt <= '0;
            if (!rx_sync)
            begin
              state <= rx_data;
              rx_active <= 1'b1;
            end
            else
            begin
              state <= rx_idle; // a glitch, not a start bit.
            end
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        rx_data:
        begin
          if (sample)
          begin
            cyc_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd8)
              state <= rx_stop; // eight data bits and the parity bit are in.
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        rx_stop:
        begin
          if (sample)
          begin
            state <= rx_idle;
            rx_valid <= 1'b1;
            rx_active <= 1'b0;
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= rx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == rx_data && sample)
    begin
      shift_q <= {rx_sync, shift_q[8:1]};
    end
    if (state == rx_stop && sample)
    begin
      rx_byte <= shift_q[7:0];
      rx_err <= ~(^shift_q) | ~rx_sync; // even count of ones or a low stop bit.
    end
  end

  a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
    else $error("rx_valid held for more than one cycle.");

endmodule

`default_nettype wire

// File: source/cmd_sequencer.sv
`default_nettype none

module cmd_sequencer #(
  parameter int BIT_CYCLES = 434,
  parameter int GAP_BITS   = 16,
  parameter int RESP_BITS  = 40
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire uart_pkg::cmd_t cmd_in,
  input  wire             cmd_vld,
  output logic            cmd_rdy,
  output logic            tx_start,
  output uart_pkg::byte_t tx_byte,
  input  wire             tx_busy,
  input  wire             rx_valid,
  input  wire uart_pkg::byte_t rx_byte,
  input  wire             rx_err,
  input  wire             rx_active,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_err
);

  localparam int max_bits = (GAP_BITS > RESP_BITS) ? GAP_BITS : RESP_BITS;
  localparam int cyc_w = $clog2(BIT_CYCLES + 1);
  localparam int bits_w = $clog2(max_bits + 1);
  localparam logic [cyc_w-1:0] cyc_last = cyc_w'(BIT_CYCLES - 1);
  // The gap closes three cycles early to cover spotting the frame end,
  // the tx_start register and the transmitter's own load cycle.
  localparam logic [cyc_w-1:0] gap_cyc_last = cyc_w'(BIT_CYCLES - 3);
  localparam logic [bits_w-1:0] gap_bit_last = bits_w'(GAP_BITS - 1);
  localparam logic [bits_w-1:0] resp_bit_last = bits_w'(RESP_BITS - 1);

  uart_pkg::seq_state_t state;
  uart_pkg::cmd_t       cmd_q;
  uart_pkg::addr_t      cmd_addr;
  logic [cyc_w-1:0]     cyc_cnt;
  logic [bits_w-1:0]    bit_cnt;
  logic                 accept;
  logic                 frame_done;
  logic                 bit_tick;
  logic                 count_en;
  logic                 gap_done;
  logic                 resp_timeout;
  logic                 resp_seen; // a response frame has started.

  assign cmd_addr = cmd_in[uart_pkg::cmd_addr_msb:uart_pkg::cmd_addr_lsb];
  assign accept = cmd_vld & cmd_rdy;
  assign frame_done = ~tx_start & ~tx_busy;
  assign bit_tick = (cyc_cnt == cyc_last);
  assign count_en = (state == uart_pkg::gap) ||
                    (state == uart_pkg::wait_resp && !resp_seen && !rx_active);
  assign gap_done = (bit_cnt == gap_bit_last) && (cyc_cnt == gap_cyc_last);
  assign resp_timeout = (bit_cnt == resp_bit_last) && bit_tick && !resp_seen && !rx_active;

  assign cmd_rdy = (state == uart_pkg::idle);
  assign read_rdy = (state == uart_pkg::report);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!count_en)
    begin
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_tick)
    begin
      cyc_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end
    else
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= uart_pkg::idle;
      tx_start <= 1'b0;
      resp_seen <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        uart_pkg::idle:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;
            state <= uart_pkg::send_addr;
          end
        end
        uart_pkg::send_addr:
        begin
          if (frame_done)
            state <= cmd_q[uart_pkg::cmd_write_bit] ? uart_pkg::gap : uart_pkg::wait_resp;
        end
        uart_pkg::gap:
        begin
          if (gap_done)
          begin
            tx_start <= 1'b1;
            state <= uart_pkg::send_data;
          end
        end
        uart_pkg::send_data:
        begin
          if (frame_done)
            state <= uart_pkg::idle;
        end
        uart_pkg::wait_resp:
        begin
          if (rx_active)
            resp_seen <= 1'b1;
          if (rx_valid)
          begin
            read_err <= rx_err;
            state <= uart_pkg::report;
          end
          else if (resp_timeout)
          begin
            read_err <= 1'b1; // no answer from the remote device.
            state <= uart_pkg::report;
          end
        end
        uart_pkg::report:
        begin
          resp_seen <= 1'b0;
          state <= uart_pkg::idle;
        end
        default:
        begin
          state <= uart_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == uart_pkg::idle && accept)
    begin
      cmd_q <= cmd_in;
      tx_byte <= {cmd_in[uart_pkg::cmd_write_bit], cmd_addr};
    end
    if (state == uart_pkg::gap && gap_done)
      tx_byte <= cmd_q[uart_pkg::cmd_data_msb:uart_pkg::cmd_data_lsb];
    if (state == uart_pkg::wait_resp)
    begin
      if (rx_valid)
        read_data <= rx_byte;
      else if (resp_timeout)
        read_data <= '0;
    end
  end

  a_read_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles in a row.");

  // only one frame may be in flight on tx.
  a_start_when_free: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start issued while the transmitter is busy.");

endmodule

`default_nettype wire

// File: source/uart_cmd_master.sv
`default_nettype none

module uart_cmd_master #(
  parameter int BIT_CYCLES = 434,
  parameter int GAP_BITS   = 16,
  parameter int RESP_BITS  = 40
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire uart_pkg::cmd_t  cmd_in,
  input  wire                  cmd_vld,
  output wire                  cmd_rdy,
  input  wire                  rx,
  output wire                  tx,
  output wire uart_pkg::byte_t read_data,
  output wire                  read_rdy,
  output wire                  read_err
);

  wire                  tx_start;
  wire uart_pkg::byte_t tx_byte;
  wire                  tx_busy;
  wire                  rx_valid;
  wire uart_pkg::byte_t rx_byte;
  wire                  rx_err;
  wire                  rx_active;

  cmd_sequencer #(
    .BIT_CYCLES(BIT_CYCLES),
    .GAP_BITS  (GAP_BITS),
    .RESP_BITS (RESP_BITS)
  ) u_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_err   (rx_err),
    .rx_active(rx_active),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  uart_tx #(
    .BIT_CYCLES(BIT_CYCLES)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .tx      (tx)
  );

  uart_rx #(
    .BIT_CYCLES(BIT_CYCLES)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_err   (rx_err),
    .rx_active(rx_active)
  );

endmodule

`default_nettype wire

// File: bench/uart_remote_model.sv
`default_nettype none

module uart_remote_model #(
  parameter int BIT_CYCLES = 16
) (
  input  wire  clk,
  input  wire  tx,
  output logic rx,
  input  wire  corrupt,
  input  wire  silent,
  output int   frame_errs,
  output int   frames_seen
);

  timeunit 1ns;
  timeprecision 100ps;

  uart_pkg::byte_t regs [128];

  // waits for a start bit on tx and samples each bit at its centre.
  task automatic read_frame(output uart_pkg::byte_t data);
    logic [10:0] bits;
    do
      @(negedge clk);
    while (tx !== 1'b0);
    repeat (BIT_CYCLES / 2) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < 11; i++)
    begin
      repeat (BIT_CYCLES) @(negedge clk);
      bits[i] = tx;
    end
    data = bits[8:1];
    frames_seen++;
    if (bits[0] !== 1'b0 || (^bits[9:1]) !== 1'b1 || bits[10] !== 1'b1)
    begin
      $display("remote model: bad frame at %0t, start %b, parity %b over data %h, stop %b",
               $time, bits[0], bits[9], bits[8:1], bits[10]);
      frame_errs++;
    end
  endtask

  task automatic send_frame(input uart_pkg::byte_t data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      rx <= bits[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx <= 1'b1;
    // the line stays high after this, so the rest of the stop bit is just idle.
    repeat (BIT_CYCLES / 2) @(negedge clk);
  endtask

  initial
  begin
    uart_pkg::byte_t head;
    uart_pkg::byte_t data;
    rx = 1'b1;
    frame_errs = 0;
    frames_seen = 0;
    for (int i = 0; i < 128; i++)
      regs[i] = uart_pkg::byte_t'(i * 37 + 11); // power-up contents differ per address.
    forever
    begin
      read_frame(head);
      if (head[7])
      begin
        read_frame(data);
        regs[head[6:0]] = data;
      end
      else
      begin
        repeat (2 * BIT_CYCLES) @(negedge clk);
        if (!silent)
          send_frame(regs[head[6:0]], corrupt);
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_uart_cmd_master.sv
`default_nettype none

module tb_uart_cmd_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int bit_cycles = 16;
  localparam int gap_bits = 16;
  localparam int resp_bits = 40;
  localparam int n_commands = 206;
  localparam int watchdog_ns = n_commands * (2 * 11 + gap_bits + resp_bits) * bit_cycles * 10
                               + 20000;

  logic            clk = 1'b0;
  logic            rst_n;
  uart_pkg::cmd_t  cmd_in;
  logic            cmd_vld;
  wire             cmd_rdy;
  wire             tx;
  wire             rx;
  wire uart_pkg::byte_t read_data;
  wire             read_rdy;
  wire             read_err;
  int              fault_mode; // 0 clean, 1 bad reply parity, 2 no reply.
  int              frame_errs;
  int              frames_seen;
  int              err_count;
  int              test_count;
  int              reads_checked;
  logic [31:0]     lfsr;
  logic            read_pending;
  logic [8:0]      read_expect; // error flag above the data byte.
  uart_pkg::byte_t shadow [128];

  uart_cmd_master #(
    .BIT_CYCLES(bit_cycles),
    .GAP_BITS  (gap_bits),
    .RESP_BITS (resp_bits)
  ) DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  uart_remote_model #(
    .BIT_CYCLES(bit_cycles)
  ) remote (
    .clk        (clk),
    .tx         (tx),
    .rx         (rx),
    .corrupt    (fault_mode == 1),
    .silent     (fault_mode == 2),
    .frame_errs (frame_errs),
    .frames_seen(frames_seen)
  );

  always #5 clk = ~clk;

  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps of x^32 + x^22 + x^2 + x + 1.
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[14:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [10:0] frame_of(input uart_pkg::byte_t b);
    logic parity;
    parity = ($countones(b) % 2 == 0); // an even count of ones needs the parity bit set.
    return {1'b1, parity, b, 1'b0}; // stop, odd parity, data, start.
  endfunction

  function automatic logic [8:0] expected_read(input uart_pkg::addr_t addr, input int fault);
    logic err;
    if (fault == 2)
      return {1'b1, 8'h00};
    err = (fault == 1);
    return {err, shadow[addr]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, want);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before)
      $display("test %0d %s: ok", test_count, name);
    else
      $display("test %0d %s: failed with %0d errors", test_count, name, err_count - errs_before);
  endtask

  task automatic send_cmd(input logic write, input uart_pkg::addr_t addr,
                          input uart_pkg::byte_t data);
    @(negedge clk);
    while (cmd_rdy !== 1'b1)
      @(negedge clk);
    if (write)
      shadow[addr] = data;
    else
    begin
      read_expect = expected_read(addr, fault_mode);
      read_pending = 1'b1;
    end
    cmd_in = {write, addr, data};
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_value("cmd_rdy after accept", cmd_rdy, 1'b0);
    while (cmd_rdy !== 1'b1)
      @(negedge clk);
    if (!write && read_pending)
    begin
      $display("read of address %0d finished without a read_rdy pulse", addr);
      err_count++;
      read_pending = 1'b0;
    end
  endtask

  // follows tx cycle by cycle from the address start bit to the end of the data frame.
  task automatic watch_write_waveform(input uart_pkg::addr_t addr, input uart_pkg::byte_t data);
    logic [10:0] addr_frame;
    logic [10:0] data_frame;
    logic        want;
    int          frame_cycles;
    int          data_start;
    int          bad;
    addr_frame = frame_of({1'b1, addr});
    data_frame = frame_of(data);
    frame_cycles = 11 * bit_cycles;
    data_start = (11 + gap_bits) * bit_cycles;
    bad = 0;
    do
      @(negedge clk);
    while (tx !== 1'b0);
    for (int k = 0; k < data_start + frame_cycles; k++)
    begin
      if (k < frame_cycles)
        want = addr_frame[k / bit_cycles];
      else if (k < data_start)
        want = 1'b1;
      else
        want = data_frame[(k - data_start) / bit_cycles];
      if (tx !== want)
        bad++;
      @(negedge clk);
    end
    check_value("tx cycles off the expected write waveform", bad, 0);
    check_value("cmd_rdy as the data stop bit ends", cmd_rdy, 1'b0);
    @(negedge clk);
    check_value("cmd_rdy one cycle after the data frame", cmd_rdy, 1'b1);
  endtask

  always @(negedge clk)
  begin
    if (rst_n && read_rdy === 1'b1)
    begin
      if (!read_pending)
      begin
        $display("read_rdy pulsed at %0t with no read outstanding", $time);
        err_count++;
      end
      else
      begin
        check_value("read_data", read_data, read_expect[7:0]);
        check_value("read_err", read_err, read_expect[8]);
        read_pending = 1'b0;
        reads_checked++;
      end
    end
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    int errs_before;
    int low_count;
    int seen_before;
    logic write;
    uart_pkg::addr_t addr;
    uart_pkg::byte_t data;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    fault_mode = 0;
    err_count = 0;
    test_count = 0;
    reads_checked = 0;
    read_pending = 1'b0;
    read_expect = '0;
    lfsr = 32'h18819dad;
    for (int i = 0; i < 128; i++)
      shadow[i] = uart_pkg::byte_t'(i * 37 + 11);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    errs_before = err_count;
    @(negedge clk);
    check_value("tx after reset", tx, 1'b1);
    check_value("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_value("read_rdy after reset", read_rdy, 1'b0);
    check_value("read_err after reset", read_err, 1'b0);
    low_count = 0;
    repeat (20 * bit_cycles)
    begin
      @(negedge clk);
      if (tx !== 1'b1)
        low_count++;
    end
    check_value("idle cycles with tx low", low_count, 0);
    finish_test("reset and idle", errs_before);

    errs_before = err_count;
    send_cmd(1'b1, 7'd5, 8'hc3);
    send_cmd(1'b0, 7'd5, 8'h00);
    check_value("model frame errors", frame_errs, 0);
    finish_test("write then read", errs_before);

    errs_before = err_count;
    seen_before = frames_seen;
    fork
      send_cmd(1'b1, 7'h2a, 8'h96);
      watch_write_waveform(7'h2a, 8'h96);
    join
    check_value("frames decoded by the model", frames_seen - seen_before, 2);
    check_value("model frame errors", frame_errs, 0);
    finish_test("write frame timing", errs_before);

    errs_before = err_count;
    repeat (200)
    begin
      write = 1'(random_bits(1));
      addr = uart_pkg::addr_t'(random_bits(7));
      data = uart_pkg::byte_t'(random_bits(8));
      send_cmd(write, addr, data);
    end
    finish_test("random commands", errs_before);

    errs_before = err_count;
    fault_mode = 1;
    send_cmd(1'b0, 7'd5, 8'h00);
    fault_mode = 0;
    send_cmd(1'b0, 7'd5, 8'h00);
    finish_test("bad reply parity", errs_before);

    errs_before = err_count;
    fault_mode = 2;
    send_cmd(1'b0, 7'd9, 8'h00);
    fault_mode = 0;
    finish_test("silent remote", errs_before);

    check_value("model frame errors", frame_errs, 0);
    $display("%0d tests, %0d reads checked, %0d errors", test_count, reads_checked, err_count);
    if (err_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_cmd_master.f
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/cmd_sequencer.sv
source/uart_cmd_master.sv
bench/uart_remote_model.sv
bench/tb_uart_cmd_master.sv
